/* hdl/exePkg.sv */
// execute stage shared types: widths, opcodes, dest select codes,
// mul/div state enum and the issue, bypass and result structs
`default_nettype none

package exePkg;

    localparam int MUL_CYCLES_DEF = 2;  // multiplier latency unless the top overrides it

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIdx_t;
    typedef logic [4:0]  aluOp_t;
    typedef logic [1:0]  dstSel_t;

    localparam aluOp_t OP_ADD   = 5'd0;
    localparam aluOp_t OP_ADDU  = 5'd1;
    localparam aluOp_t OP_SUB   = 5'd2;
    localparam aluOp_t OP_SUBU  = 5'd3;
    localparam aluOp_t OP_AND   = 5'd4;
    localparam aluOp_t OP_OR    = 5'd5;
    localparam aluOp_t OP_XOR   = 5'd6;
    localparam aluOp_t OP_NOR   = 5'd7;
    localparam aluOp_t OP_SLT   = 5'd8;
    localparam aluOp_t OP_SLTU  = 5'd9;
    localparam aluOp_t OP_SLL   = 5'd10;
    localparam aluOp_t OP_SRL   = 5'd11;
    localparam aluOp_t OP_SRA   = 5'd12;
    localparam aluOp_t OP_LUI   = 5'd13;
    localparam aluOp_t OP_MULT  = 5'd14;
    localparam aluOp_t OP_MULTU = 5'd15;
    localparam aluOp_t OP_DIV   = 5'd16;
    localparam aluOp_t OP_DIVU  = 5'd17;
    localparam aluOp_t OP_MFHI  = 5'd18;
    localparam aluOp_t OP_MFLO  = 5'd19;
    localparam aluOp_t OP_MTHI  = 5'd20;
    localparam aluOp_t OP_MTLO  = 5'd21;
    localparam aluOp_t OP_BEQ   = 5'd22;
    localparam aluOp_t OP_BNE   = 5'd23;

    localparam dstSel_t DST_RD = 2'd0;
    localparam dstSel_t DST_RT = 2'd1;
    localparam dstSel_t DST_RA = 2'd2;  // link register

    typedef enum logic [1:0] {IDLE, MULBUSY, DIVBUSY, DONE} mdState_e;

    typedef struct packed {
        aluOp_t  op;
        regIdx_t rs;
        regIdx_t rt;
        regIdx_t rd;
        word_t   busA;      // regfile read of rs
        word_t   busB;      // regfile read of rt
        word_t   imm;       // already extended by decode
        logic [4:0] shamt;
        logic    useImm;
        logic    useShamt;
        dstSel_t dstSel;
        logic    regWr;
    } issue_t;

    typedef struct packed {
        logic    regWr;
        regIdx_t dst;
        word_t   result;
    } fwdSrc_t;

    typedef struct packed {
        word_t   aluOut;
        regIdx_t dst;
        logic    regWr;
        logic    overflow;
        logic    branchTaken;
    } exeOut_t;

    function automatic logic isMulDiv(aluOp_t op);
        return (op == OP_MULT) || (op == OP_MULTU) || (op == OP_DIV) || (op == OP_DIVU);
    endfunction

endpackage

`default_nettype wire

/* hdl/exeLatch.sv */
// decode to execute pipeline register with flush, hold and valid bit
`timescale 1ns/1ns
`default_nettype none

module exeLatch (
    input  logic           clk,
    input  logic           rstN,
    input  logic           flush,
    input  logic           hold,
    input  logic           issueValid,
    input  exePkg::issue_t issue,
    output exePkg::issue_t exeInstr,
    output logic           exeValid
);

    logic load;

    assign load = issueValid && !hold;

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            exeValid <= 1'b0;       // bubble
        end else if (!hold) begin
            exeValid <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            exeInstr <= issue;
        end
    end

    // decode must wait out a mul/div stall before it issues again
    noIssueWhileHeld: assert property (
        @(posedge clk) disable iff (!rstN) hold |-> !issueValid
    );

endmodule

`default_nettype wire

/* hdl/operandForward.sv */
// operand bypass from memory and write-back, immediate / shamt
// operand choice and destination register select
`timescale 1ns/1ns
`default_nettype none

module operandForward (
    input  exePkg::issue_t  exeInstr,
    input  exePkg::fwdSrc_t memFwd,
    input  exePkg::fwdSrc_t wbFwd,
    output exePkg::word_t   opA,
    output exePkg::word_t   opB,
    output exePkg::word_t   aluA,
    output exePkg::word_t   aluB,
    output exePkg::regIdx_t dst
);

    import exePkg::*;

    // memory stage is younger, so it wins over write-back
    function automatic word_t bypass(regIdx_t idx, word_t regVal, fwdSrc_t mem, fwdSrc_t wb);
        word_t val;
        val = regVal;
        if (idx != '0) begin
            if (mem.regWr && mem.dst == idx) begin
                val = mem.result;
            end else if (wb.regWr && wb.dst == idx) begin
                val = wb.result;
            end
        end
        return val;
    endfunction

    assign opA = bypass(exeInstr.rs, exeInstr.busA, memFwd, wbFwd);
    assign opB = bypass(exeInstr.rt, exeInstr.busB, memFwd, wbFwd);

    assign aluA = exeInstr.useShamt ? {27'b0, exeInstr.shamt} : opA;  // sll/srl/sra
    assign aluB = exeInstr.useImm ? exeInstr.imm : opB;

    always_comb begin
        case (exeInstr.dstSel)
            DST_RD:  dst = exeInstr.rd;
            DST_RT:  dst = exeInstr.rt;    // immediate forms
            DST_RA:  dst = regIdx_t'(31);  // jal / bal
            default: dst = exeInstr.rd;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/aluCore.sv */
// integer ALU: add/sub with overflow, logic, shifts, slt, lui,
// and BEQ/BNE resolve on the bypassed operands
`timescale 1ns/1ns
`default_nettype none

module aluCore (
    input  exePkg::aluOp_t op,
    input  exePkg::word_t  aluA,
    input  exePkg::word_t  aluB,
    input  exePkg::word_t  opA,
    input  exePkg::word_t  opB,
    output exePkg::word_t  aluOut,
    output logic           overflow,
    output logic           branchTaken
);

    import exePkg::*;

    word_t      sum;
    word_t      diff;
    logic [4:0] sa;

    assign sum  = aluA + aluB;
    assign diff = aluA - aluB;
    assign sa   = aluA[4:0];  // shamt or rs[4:0]

    always_comb begin
        aluOut      = '0;
        overflow    = 1'b0;
        branchTaken = 1'b0;
        case (op)
            OP_ADD: begin
                aluOut   = sum;
                overflow = (aluA[31] == aluB[31]) && (sum[31] != aluA[31]);
            end
            OP_SUB: begin
                aluOut   = diff;
                overflow = (aluA[31] != aluB[31]) && (diff[31] != aluA[31]);
            end
            OP_ADDU: aluOut = sum;
            OP_SUBU: aluOut = diff;
            OP_AND:  aluOut = aluA & aluB;
            OP_OR:   aluOut = aluA | aluB;
            OP_XOR:  aluOut = aluA ^ aluB;
            OP_NOR:  aluOut = ~(aluA | aluB);
            OP_SLT:  aluOut = {31'b0, $signed(aluA) < $signed(aluB)};
            OP_SLTU: aluOut = {31'b0, aluA < aluB};
            OP_SLL:  aluOut = aluB << sa;
            OP_SRL:  aluOut = aluB >> sa;
            OP_SRA:  aluOut = $signed(aluB) >>> sa;
            OP_LUI:  aluOut = {aluB[15:0], 16'b0};
            OP_MTHI, OP_MTLO: aluOut = opA;  // word being moved
            OP_BEQ:  branchTaken = (opA == opB);
            OP_BNE:  branchTaken = (opA != opB);
            default: aluOut = '0;  // mul/div and MFHI/MFLO come from hiLoFile
        endcase
    end

endmodule

`default_nettype wire

/* hdl/mulDivUnit.sv */
// multi-cycle multiplier (registered product) and restoring divider
// with sign fix-up, stall and one-cycle finish
`timescale 1ns/1ns
`default_nettype none

module mulDivUnit #(
    parameter int MUL_CYCLES = exePkg::MUL_CYCLES_DEF
) (
    input  logic           clk,
    input  logic           rstN,
    input  logic           flush,
    input  logic           start,
    input  exePkg::aluOp_t op,
    input  exePkg::word_t  opA,
    input  exePkg::word_t  opB,
    output exePkg::word_t  mdHi,
    output exePkg::word_t  mdLo,
    output logic           mdFinish,
    output logic           mdStall
);

    import exePkg::*;

    localparam logic [5:0] MUL_LAST  = 6'(MUL_CYCLES - 1);
    localparam logic [5:0] DIV_STEPS = 6'd32;  // fix-up runs at this count

    mdState_e    state;
    logic [5:0]  cnt;
    logic [63:0] prod;
    logic [32:0] rem;       // partial remainder
    word_t       quot;      // dividend shifts out as quotient shifts in
    word_t       divisor;
    logic        negQ;
    logic        negR;
    logic        isSigned;
    logic        isMul;
    logic        accept;
    logic        busy;
    logic        lastStep;
    logic [63:0] extA;
    logic [63:0] extB;
    logic [32:0] remShift;
    logic [32:0] remDiff;
    word_t       quotFix;
    word_t       remFix;

    assign isSigned = (op == OP_MULT) || (op == OP_DIV);
    assign isMul    = (op == OP_MULT) || (op == OP_MULTU);
    assign accept   = (state == IDLE) && start;
    assign busy     = (state == MULBUSY) || (state == DIVBUSY);

    assign extA = {{32{isSigned & opA[31]}}, opA};
    assign extB = {{32{isSigned & opB[31]}}, opB};

    assign remShift = {rem[31:0], quot[31]};
    assign remDiff  = remShift - {1'b0, divisor};

    // divide by zero leaves the dividend as remainder on its own
    assign quotFix = (divisor == '0) ? '1 : (negQ ? -quot : quot);
    assign remFix  = negR ? -rem[31:0] : rem[31:0];

    assign lastStep = (state == MULBUSY) ? (cnt == MUL_LAST) : (cnt == DIV_STEPS);
    assign mdFinish = busy && lastStep && !flush;
    assign mdStall  = accept || busy;
    assign mdHi     = (state == MULBUSY) ? prod[63:32] : remFix;
    assign mdLo     = (state == MULBUSY) ? prod[31:0] : quotFix;

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            state <= IDLE;      // abort, nothing reaches HI/LO
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    cnt <= '0;
                    if (start) begin
                        state <= isMul ? MULBUSY : DIVBUSY;
                    end
                end
                MULBUSY, DIVBUSY: begin
                    cnt <= cnt + 6'd1;
                    if (lastStep) begin
                        state <= DONE;
                    end
                end
                default: state <= IDLE;  // DONE, instruction retires
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            prod    <= extA * extB;
            quot    <= (isSigned && opA[31]) ? -opA : opA;
            divisor <= (isSigned && opB[31]) ? -opB : opB;
            rem     <= '0;
            negQ    <= isSigned && (opA[31] ^ opB[31]);
            negR    <= isSigned && opA[31];
        end else if (state == DIVBUSY && cnt < DIV_STEPS) begin
            if (!remDiff[32]) begin
                rem  <= remDiff;
                quot <= {quot[30:0], 1'b1};
            end else begin
                rem  <= remShift;
                quot <= {quot[30:0], 1'b0};
            end
        end
    end

    finishOneCycle: assert property (
        @(posedge clk) disable iff (!rstN) mdFinish |=> !mdFinish
    );

    noFinishWhenIdle: assert property (
        @(posedge clk) disable iff (!rstN) mdFinish |-> state != IDLE
    );

endmodule

`default_nettype wire

/* hdl/hiLoFile.sv */
// HI/LO registers and the retired result word select
`timescale 1ns/1ns
`default_nettype none

module hiLoFile (
    input  logic           clk,
    input  logic           rstN,
    input  logic           mdFinish,
    input  exePkg::word_t  mdHi,
    input  exePkg::word_t  mdLo,
    input  logic           retire,
    input  exePkg::aluOp_t op,
    input  exePkg::word_t  opA,
    input  exePkg::word_t  aluOut,
    output exePkg::word_t  resultWord
);

    import exePkg::*;

    word_t hi;
    word_t lo;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            hi <= '0;
            lo <= '0;
        end else if (mdFinish) begin
            hi <= mdHi;             // remainder for divide
            lo <= mdLo;
        end else if (retire && op == OP_MTHI) begin
            hi <= opA;
        end else if (retire && op == OP_MTLO) begin
            lo <= opA;
        end
    end

    always_comb begin : resultSel
        case (op)
            OP_MFHI: resultWord = hi;
            OP_MFLO: resultWord = lo;
            default: resultWord = aluOut;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/exeStage.sv */
// execute stage top: latch, bypass, ALU, mul/div, HI/LO
// plus start, retire and regWr glue
`timescale 1ns/1ns
`default_nettype none

module exeStage #(
    parameter int MUL_CYCLES = exePkg::MUL_CYCLES_DEF
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            flush,
    input  logic            issueValid,
    input  exePkg::issue_t  issue,
    input  exePkg::fwdSrc_t memFwd,
    input  exePkg::fwdSrc_t wbFwd,
    output exePkg::exeOut_t result,
    output logic            resultValid,
    output logic            mdStall
);

    import exePkg::*;

    issue_t  exeInstr;
    logic    exeValid;
    word_t   opA;
    word_t   opB;
    word_t   aluA;
    word_t   aluB;
    regIdx_t dst;
    word_t   aluOut;
    logic    overflow;
    logic    branchTaken;
    word_t   mdHi;
    word_t   mdLo;
    logic    mdFinish;
    logic    start;
    logic    retire;
    logic    isBranch;
    word_t   resultWord;

    assign start    = exeValid && isMulDiv(exeInstr.op);  // unit ignores it once done
    assign retire   = exeValid && !mdStall;
    assign isBranch = (exeInstr.op == OP_BEQ) || (exeInstr.op == OP_BNE);

    assign resultValid        = retire;
    assign result.aluOut      = resultWord;
    assign result.dst         = dst;
    assign result.regWr       = exeInstr.regWr && !overflow && !isBranch;
    assign result.overflow    = overflow;
    assign result.branchTaken = branchTaken;

    exeLatch i_exeLatch (
        .clk        (clk),
        .rstN       (rstN),
        .flush      (flush),
        .hold       (mdStall),
        .issueValid (issueValid),
        .issue      (issue),
        .exeInstr   (exeInstr),
        .exeValid   (exeValid)
    );

    operandForward i_operandForward (
        .exeInstr (exeInstr),
        .memFwd   (memFwd),
        .wbFwd    (wbFwd),
        .opA      (opA),
        .opB      (opB),
        .aluA     (aluA),
        .aluB     (aluB),
        .dst      (dst)
    );

    aluCore i_aluCore (
        .op          (exeInstr.op),
        .aluA        (aluA),
        .aluB        (aluB),
        .opA         (opA),
        .opB         (opB),
        .aluOut      (aluOut),
        .overflow    (overflow),
        .branchTaken (branchTaken)
    );

    mulDivUnit #(
        .MUL_CYCLES (MUL_CYCLES)
    ) i_mulDivUnit (
        .clk      (clk),
        .rstN     (rstN),
        .flush    (flush),
        .start    (start),
        .op       (exeInstr.op),
        .opA      (opA),            // bypassed, not the shamt/imm choice
        .opB      (opB),
        .mdHi     (mdHi),
        .mdLo     (mdLo),
        .mdFinish (mdFinish),
        .mdStall  (mdStall)
    );

    hiLoFile i_hiLoFile (
        .clk        (clk),
        .rstN       (rstN),
        .mdFinish   (mdFinish),
        .mdHi       (mdHi),
        .mdLo       (mdLo),
        .retire     (retire),
        .op         (exeInstr.op),
        .opA        (opA),
        .aluOut     (aluOut),
        .resultWord (resultWord)
    );

endmodule

`default_nettype wire

/* testbench/exeStageTb.sv */
// execute stage testbench: clock, reset, stimulus file reader,
// typed compare tasks and bounded waits
`timescale 1ns/1ns
`default_nettype none

module exeStageTb;

    import exePkg::*;

    localparam int NCOL     = 24;
    localparam int MAX_WAIT = 100;  // cycles, well past a divide
    localparam int WATCH    = 40;

    logic    clk;
    logic    rstN;
    logic    flush;
    logic    issueValid;
    issue_t  issue;
    fwdSrc_t memFwd;
    fwdSrc_t wbFwd;
    exeOut_t result;
    logic    resultValid;
    logic    mdStall;
    word_t   col [NCOL];    // fields of the current stim line

    exeStage #(
        .MUL_CYCLES (2)
    ) i_exeStage (
        .clk         (clk),
        .rstN        (rstN),
        .flush       (flush),
        .issueValid  (issueValid),
        .issue       (issue),
        .memFwd      (memFwd),
        .wbFwd       (wbFwd),
        .result      (result),
        .resultValid (resultValid),
        .mdStall     (mdStall)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkWord(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            abortRun($sformatf("CHECK FAILED at %0t ns: %s = %h, expected %h",
                               $time, name, got, want));
        end
    endtask

    task automatic checkIdx(input string name, input regIdx_t got, input regIdx_t want);
        if (got !== want) begin
            abortRun($sformatf("CHECK FAILED at %0t ns: %s = %0d, expected %0d",
                               $time, name, got, want));
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic want);
        if (got !== want) begin
            abortRun($sformatf("CHECK FAILED at %0t ns: %s = %b, expected %b",
                               $time, name, got, want));
        end
    endtask

    task automatic waitStallLow();
        int n;
        n = 0;
        while (mdStall !== 1'b0) begin
            @(negedge clk);
            n++;
            if (n > MAX_WAIT) begin
                abortRun("timeout: mdStall stayed high");
            end
        end
    endtask

    task automatic flushDivide();
        repeat (3) @(negedge clk);  // divide still running
        @(posedge clk);
        #1;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        @(negedge clk);
        checkFlag("mdStall", mdStall, 1'b0);
        repeat (WATCH) begin
            @(negedge clk);
            checkFlag("resultValid", resultValid, 1'b0);  // aborted op never retires
        end
    endtask

    task automatic runLine();
        issue_t  ins;
        exeOut_t want;
        logic    isMd;
        int      waited;
        ins.op           = col[0][4:0];
        ins.rs           = col[1][4:0];
        ins.rt           = col[2][4:0];
        ins.rd           = col[3][4:0];
        ins.busA         = col[4];
        ins.busB         = col[5];
        ins.imm          = col[6];
        ins.shamt        = col[7][4:0];
        ins.useImm       = col[8][0];
        ins.useShamt     = col[9][0];
        ins.dstSel       = col[10][1:0];
        ins.regWr        = col[11][0];
        want.aluOut      = col[19];
        want.dst         = col[20][4:0];
        want.regWr       = col[21][0];
        want.overflow    = col[22][0];
        want.branchTaken = col[23][0];
        isMd = ins.op inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU};

        waitStallLow();
        @(posedge clk);
        #1;
        issue         = ins;
        memFwd.regWr  = col[12][0];
        memFwd.dst    = col[13][4:0];
        memFwd.result = col[14];
        wbFwd.regWr   = col[15][0];
        wbFwd.dst     = col[16][4:0];
        wbFwd.result  = col[17];
        issueValid    = 1'b1;
        @(posedge clk);
        #1;
        issueValid = 1'b0;
        @(negedge clk);
        if (isMd) begin
            checkFlag("mdStall", mdStall, 1'b1);  // stall right after issue
        end
        if (col[18][0]) begin
            flushDivide();
        end else begin
            waited = 0;
            while (resultValid !== 1'b1) begin
                @(negedge clk);
                waited++;
                if (waited > MAX_WAIT) begin
                    abortRun("timeout: resultValid never rose");
                end
            end
            if (!isMd && waited != 0) begin
                abortRun("ALU result did not come one cycle after issue");
            end
            checkWord("result.aluOut", result.aluOut, want.aluOut);
            checkIdx("result.dst", result.dst, want.dst);
            checkFlag("result.regWr", result.regWr, want.regWr);
            checkFlag("result.overflow", result.overflow, want.overflow);
            checkFlag("result.branchTaken", result.branchTaken, want.branchTaken);
            @(negedge clk);
            checkFlag("resultValid", resultValid, 1'b0);  // one cycle wide
        end
    endtask

    initial begin
        int    fd;
        int    nRead;
        int    nLines;
        string line;
        rstN       = 1'b0;
        flush      = 1'b0;
        issueValid = 1'b0;
        issue      = '0;
        memFwd     = '0;
        wbFwd      = '0;
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        @(negedge clk);
        checkFlag("resultValid", resultValid, 1'b0);
        checkFlag("mdStall", mdStall, 1'b0);

        fd = $fopen("testbench/exeStim.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open testbench/exeStim.txt");
        end
        nLines = 0;
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "/") begin
                nRead = $sscanf(line,
                    "%d %d %d %d %h %h %h %d %d %d %d %d %d %d %h %d %d %h %d %h %d %d %d %d",
                    col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                    col[8], col[9], col[10], col[11], col[12], col[13], col[14], col[15],
                    col[16], col[17], col[18], col[19], col[20], col[21], col[22], col[23]);
                if (nRead != NCOL) begin
                    abortRun($sformatf("malformed stimulus line: %s", line));
                end
                runLine();
                nLines++;
            end
        end
        $fclose(fd);
        if (nLines == 0) begin
            abortRun("no stimulus lines were read");
        end
        $display("%0d instructions checked", nLines);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/exeStim.txt */
// op rs rt rd busA busB imm shamt useImm useShamt dstSel regWr memRegWr memDst memResult
// wbRegWr wbDst wbResult flush expAluOut expDst expRegWr expOverflow expBranch (words hex)
0 4 5 6 7fffffff 00000001 00000000 0 0 0 0 1 0 0 00000000 0 0 00000000 0 80000000 6 0 1 0
1 4 5 6 7fffffff 00000001 00000000 0 0 0 0 1 0 0 00000000 0 0 00000000 0 80000000 6 1 0 0
2 7 8 9 80000000 00000001 00000000 0 0 0 0 1 0 0 00000000 0 0 00000000 0 7fffffff 9 0 1 0
3 7 8 9 80000000 00000001 00000000 0 0 0 0 1 0 0 00000000 0 0 00000000 0 7fffffff 9 1 0 0
4 1 10 0 f0f0ff00 12345678 0000ffff 0 1 0 1 1 0 0 00000000 0 0 00000000 0 0000ff00 10 1 0 0
5 1 2 11 0f0f0000 000000f0 00000000 0 0 0 0 1 0 0 00000000 0 0 00000000 0 0f0f00f0 11 1 0 0
6 1 2 12 ffff0000 0f0f0f0f 00000000 0 0 0 0 1 0 0 00000000 0 0 00000000 0 f0f00f0f 12 1 0 0
7 1 2 13 00ff00ff 0f000000 00000000 0 0 0 0 1 0 0 00000000 0 0 00000000 0 f000ff00 13 1 0 0
8 1 2 14 fffffffe 00000001 00000000 0 0 0 0 1 0 0 00000000 0 0 00000000 0 00000001 14 1 0 0
9 1 2 15 fffffffe 00000001 00000000 0 0 0 0 1 0 0 00000000 0 0 00000000 0 00000000 15 1 0 0
10 0 2 16 00000000 000000f1 00000000 4 0 1 0 1 0 0 00000000 0 0 00000000 0 00000f10 16 1 0 0
11 0 2 17 00000000 80000000 00000000 31 0 1 0 1 0 0 00000000 0 0 00000000 0 00000001 17 1 0 0
12 0 2 18 00000000 80000000 00000000 4 0 1 0 1 0 0 00000000 0 0 00000000 0 f8000000 18 1 0 0
13 0 19 0 00000000 00000000 00001234 0 1 0 1 1 0 0 00000000 0 0 00000000 0 12340000 19 1 0 0
0 3 4 20 00000001 00000002 00000000 0 0 0 0 1 1 3 00000100 1 4 00000020 0 00000120 20 1 0 0
1 5 6 21 00000001 00000002 00000000 0 0 0 0 1 1 5 00001000 1 5 00002000 0 00001002 21 1 0 0
1 0 7 22 00000010 00000003 00000000 0 0 0 0 1 1 0 ffffffff 0 7 00005000 0 00000013 22 1 0 0
22 1 2 0 00000005 00000009 00000000 0 0 0 0 0 1 2 00000005 0 0 00000000 0 00000000 0 0 0 1
23 1 2 0 00000005 00000006 00000000 0 0 0 0 0 0 0 00000000 1 2 00000005 0 00000000 0 0 0 0
14 1 2 0 fffffffd 00000007 00000000 0 0 0 0 0 0 0 00000000 0 0 00000000 0 00000000 0 0 0 0
18 0 0 8 00000000 00000000 00000000 0 0 0 0 1 0 0 00000000 0 0 00000000 0 ffffffff 8 1 0 0
19 0 0 9 00000000 00000000 00000000 0 0 0 0 1 0 0 00000000 0 0 00000000 0 ffffffeb 9 1 0 0
15 1 2 0 ffffffff 00000002 00000000 0 0 0 0 0 0 0 00000000 0 0 00000000 0 00000000 0 0 0 0
18 0 0 8 00000000 00000000 00000000 0 0 0 0 1 0 0 00000000 0 0 00000000 0 00000001 8 1 0 0
16 1 2 0 fffffff9 00000002 00000000 0 0 0 0 0 0 0 00000000 0 0 00000000 0 00000000 0 0 0 0
18 0 0 8 00000000 00000000 00000000 0 0 0 0 1 0 0 00000000 0 0 00000000 0 ffffffff 8 1 0 0
19 0 0 9 00000000 00000000 00000000 0 0 0 0 1 0 0 00000000 0 0 00000000 0 fffffffd 9 1 0 0
17 1 2 0 00000064 00000007 00000000 0 0 0 0 0 0 0 00000000 0 0 00000000 0 00000000 0 0 0 0
19 0 0 9 00000000 00000000 00000000 0 0 0 0 1 0 0 00000000 0 0 00000000 0 0000000e 9 1 0 0
16 1 2 0 ffffffd6 00000000 00000000 0 0 0 0 0 0 0 00000000 0 0 00000000 0 00000000 0 0 0 0
18 0 0 8 00000000 00000000 00000000 0 0 0 0 1 0 0 00000000 0 0 00000000 0 ffffffd6 8 1 0 0
19 0 0 9 00000000 00000000 00000000 0 0 0 0 1 0 0 00000000 0 0 00000000 0 ffffffff 9 1 0 0
20 3 0 0 12345678 00000000 00000000 0 0 0 0 0 0 0 00000000 0 0 00000000 0 12345678 0 0 0 0
21 4 0 0 9abcdef0 00000000 00000000 0 0 0 0 0 0 0 00000000 0 0 00000000 0 9abcdef0 0 0 0 0
19 0 0 9 00000000 00000000 00000000 0 0 0 0 1 0 0 00000000 0 0 00000000 0 9abcdef0 9 1 0 0
16 1 2 0 00000100 00000003 00000000 0 0 0 0 0 0 0 00000000 0 0 00000000 1 00000000 0 0 0 0
18 0 0 8 00000000 00000000 00000000 0 0 0 0 1 0 0 00000000 0 0 00000000 0 12345678 8 1 0 0

/* list.f */
hdl/exePkg.sv
hdl/exeLatch.sv
hdl/operandForward.sv
hdl/aluCore.sv
hdl/mulDivUnit.sv
hdl/hiLoFile.sv
hdl/exeStage.sv
testbench/exeStageTb.sv

/* runSim.sh */
#!/bin/sh
# Verilator build and run of the execute stage testbench
rm -rf obj_dir sim.log
verilator --binary --assert -f list.f --top-module exeStageTb -o exeSim \
    || { echo "build failed"; exit 1; }
./obj_dir/exeSim 2>&1 | tee sim.log
grep -qF '*** TEST FAILED ***' sim.log && { echo "simulation failed"; exit 1; }
grep -qF '*** TEST PASSED ***' sim.log || { echo "no pass message in sim.log"; exit 1; }
echo "simulation passed"
